// ==== src/ber_pkg.sv ====
package ber_pkg;

  // width of the wrapping error count carried on the test bus
  localparam int SAMPLE_W = 7;

  // the bit and error counters are wide enough to run for days
  localparam int COUNT_W = 44;
  localparam int EXCP_W = 32;

  // register read-out words and the programmed threshold
  localparam int WORD_W = 32;
  localparam int THRESH_W = 8;

  // flops in every single-bit synchronizer chain
  localparam int SYNC_DEPTH = 3;

  // FIFO address width gives 8 entries
  localparam int FIFO_AW = 3;

  // window length and accepted-sample timer
  localparam int WINDOW_W = 32;

  // clk cycles spent in flush after count_rst drops, and the counter width for it
  localparam int FLUSH_CYCLES = 16;
  localparam int FLUSH_W = $clog2(FLUSH_CYCLES);

  // measurement states of the control FSM
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FLUSH = 3'd1,
    ST_PRIME = 3'd2,
    ST_COUNT = 3'd3,
    ST_DONE  = 3'd4
  } ber_state_t;

  // all three counts travel together so a snapshot copies them in one edge
  typedef struct packed {
    logic [COUNT_W-1:0] bits;
    logic [COUNT_W-1:0] errors;
    logic [EXCP_W-1:0]  exceptions;
  } ber_counts_t;

endpackage

// ==== src/ber_sync_bit.sv ====
`timescale 1ns/1ps

module ber_sync_bit
  import ber_pkg::*;
#(
  parameter logic RESET_VAL = 1'b0
) (
  input  logic clk,
  input  logic reset,
  input  logic d,
  output logic q
);

  // the chain shifts from bit 0 towards the top bit
  logic [SYNC_DEPTH-1:0] sync_q;

  // the whole chain loads the reset value so q is defined during reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_q <= {SYNC_DEPTH{RESET_VAL}};
    end else begin
      sync_q <= {sync_q[SYNC_DEPTH-2:0], d};
    end
  end

  // only the last flop is seen by the destination domain
  assign q = sync_q[SYNC_DEPTH-1];

endmodule

// ==== src/ber_async_fifo.sv ====
`timescale 1ns/1ps

module ber_async_fifo
  import ber_pkg::*;
(
  input  logic                wr_clk,
  input  logic                wr_reset,
  input  logic                wr_en,
  input  logic [SAMPLE_W-1:0] wr_data,
  input  logic                clk,
  input  logic                reset,
  input  logic                rd_en,
  output logic [SAMPLE_W-1:0] rd_data,
  output logic                empty
);

  logic [SAMPLE_W-1:0] mem [2**FIFO_AW];

  // pointers carry one extra bit to tell full from empty
  logic [FIFO_AW:0] wr_bin;
  logic [FIFO_AW:0] wr_bin_next;
  logic [FIFO_AW:0] wr_gray;
  logic [FIFO_AW:0] rd_bin;
  logic [FIFO_AW:0] rd_bin_next;
  logic [FIFO_AW:0] rd_gray;

  // gray pointers after two flops in the opposite domain
  logic [FIFO_AW:0] rd_gray_w1;
  logic [FIFO_AW:0] rd_gray_w2;
  logic [FIFO_AW:0] wr_gray_r1;
  logic [FIFO_AW:0] wr_gray_r2;

  logic full;
  logic wr_push;
  logic rd_pop;

  // full when the top two gray bits differ and the rest match
  assign full = (wr_gray == {~rd_gray_w2[FIFO_AW:FIFO_AW-1], rd_gray_w2[FIFO_AW-2:0]});
  assign wr_push = wr_en && !full;
  assign wr_bin_next = wr_bin + {{FIFO_AW{1'b0}}, wr_push};

  // storage has no reset, entries are only read once a pointer covers them
  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_bin[FIFO_AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk or posedge wr_reset) begin
    if (wr_reset) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      wr_bin     <= wr_bin_next;
      wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
    end
  end

  // empty when the local read pointer has caught up with the synced write pointer
  assign empty = (rd_gray == wr_gray_r2);
  assign rd_pop = rd_en && !empty;
  assign rd_bin_next = rd_bin + {{FIFO_AW{1'b0}}, rd_pop};

  // first word fall through, the head entry is always on rd_data
  assign rd_data = mem[rd_bin[FIFO_AW-1:0]];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      rd_bin     <= rd_bin_next;
      rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
    end
  end

  // the test bus cannot be stalled so a full FIFO loses samples
  ap_no_overflow: assert property (@(posedge wr_clk) disable iff (wr_reset)
    wr_en |-> !full)
    else $error("ber_async_fifo sample dropped on a full FIFO");

  // the reader is expected to qualify every read with not empty
  ap_no_underflow: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> !empty)
    else $error("ber_async_fifo read while empty");

endmodule

// ==== src/ber_ctrl_if.sv ====
`timescale 1ns/1ps

interface ber_ctrl_if;

  // one-cycle clear of every count on a count_rst rising edge
  logic clear;
  // first read after a clear which only loads the previous sample
  logic prime;
  // a counted FIFO read
  logic take;
  // one-cycle copy of the live counts into the read-out registers
  logic snap;

  modport controller (output clear, output prime, output take, output snap);

  modport accumulator (input clear, input prime, input take, input snap);

  // the timer only cares about accepted samples and the clear
  modport timer (input clear, input take);

endinterface

// ==== src/ber_ctrl_fsm.sv ====
`timescale 1ns/1ps

module ber_ctrl_fsm
  import ber_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           count_en,
  input  logic           count_rst,
  input  logic           snap_shot,
  input  logic           empty,
  input  logic           window_done,
  output logic           rd_en,
  ber_ctrl_if.controller ctrl,
  output ber_state_t     state
);

  logic               count_rst_q;
  logic               snap_shot_q;
  logic               rst_edge;
  logic               snap_edge;
  logic [FLUSH_W-1:0] flush_cnt;
  logic               read_state;

  // previous-cycle copies of the request bits for edge detection
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count_rst_q <= 1'b0;
      snap_shot_q <= 1'b0;
    end else begin
      count_rst_q <= count_rst;
      snap_shot_q <= snap_shot;
    end
  end

  // both requests act on the very edge where they are first seen high
  assign rst_edge = count_rst && !count_rst_q;
  assign snap_edge = snap_shot && !snap_shot_q;

  // reads stop as soon as the window is full so no extra sample slips in
  assign read_state = (state == ST_PRIME) || ((state == ST_COUNT) && !window_done);
  assign rd_en = count_en && !empty && !rst_edge && read_state;

  assign ctrl.clear = rst_edge;
  assign ctrl.snap = snap_edge;
  assign ctrl.prime = rd_en && (state == ST_PRIME);
  assign ctrl.take = rd_en && (state == ST_COUNT);

  // a count reset restarts the measurement from any state including done
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ST_IDLE;
      flush_cnt <= '0;
    end else if (rst_edge) begin
      state     <= ST_FLUSH;
      flush_cnt <= '0;
    end else begin
      case (state)
        ST_FLUSH: begin
          // hold while count_rst is high so the write side stays in reset
          if (count_rst) begin
            flush_cnt <= '0;
          end else if (flush_cnt == FLUSH_W'(FLUSH_CYCLES - 1)) begin
            state <= ST_PRIME;
          end else begin
            flush_cnt <= flush_cnt + 1'b1;
          end
        end
        ST_PRIME: begin
          if (rd_en) begin
            state <= ST_COUNT;
          end
        end
        ST_COUNT: begin
          if (window_done) begin
            state <= ST_DONE;
          end
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

  // the accumulator would double count a sample that is both primed and taken
  ap_prime_take_excl: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.prime && ctrl.take))
    else $error("prime and take in the same cycle");

  // only one sample per measurement may be masked
  ap_prime_once: assert property (@(posedge clk) disable iff (reset)
    ctrl.prime |=> (!ctrl.prime until ctrl.clear))
    else $error("second prime without a clear");

endmodule

// ==== src/ber_window_timer.sv ====
`timescale 1ns/1ps

module ber_window_timer
  import ber_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [WINDOW_W-1:0] window_len,
  ber_ctrl_if.timer           ctrl,
  output logic                window_done
);

  // accepted samples since the last clear
  logic [WINDOW_W-1:0] taken;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      taken <= '0;
    end else if (ctrl.clear) begin
      taken <= '0;
    end else if (ctrl.take) begin
      taken <= taken + 1'b1;
    end
  end

  // a zero window length leaves the measurement running forever
  assign window_done = (window_len != '0) && (taken == window_len);

  // the FSM must stop reading once the window is complete
  ap_no_take_after_done: assert property (@(posedge clk) disable iff (reset)
    window_done |-> !ctrl.take)
    else $error("sample taken past the end of the window");

endmodule

// ==== src/ber_accumulator.sv ====
`timescale 1ns/1ps

module ber_accumulator
  import ber_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [THRESH_W-1:0] threshold,
  input  logic [SAMPLE_W-1:0] rd_data,
  ber_ctrl_if.accumulator     ctrl,
  output ber_counts_t         snap_counts
);

  ber_counts_t         live;
  logic [SAMPLE_W-1:0] prev_sample;
  logic [SAMPLE_W-1:0] delta;
  logic                step_ok;
  logic                restart_ok;

  // the subtraction stays 7 bits wide so a wrap through 127 gives a small step
  assign delta = rd_data - prev_sample;

  // a small forward step is a normal increment of the error counter
  assign step_ok = (THRESH_W'(delta) <= threshold);

  // a small absolute value after a big drop means the counter was restarted
  assign restart_ok = (THRESH_W'(rd_data) <= threshold);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      live        <= '0;
      prev_sample <= '0;
    end else if (ctrl.clear) begin
      live        <= '0;
      prev_sample <= '0;
    end else if (ctrl.prime) begin
      // the first sample has no predecessor and only seeds the difference
      prev_sample <= rd_data;
    end else if (ctrl.take) begin
      prev_sample <= rd_data;
      if (step_ok) begin
        live.bits   <= live.bits + 1'b1;
        live.errors <= live.errors + COUNT_W'(delta);
      end else if (restart_ok) begin
        // the errors seen since the restart are the sample itself
        live.bits   <= live.bits + 1'b1;
        live.errors <= live.errors + COUNT_W'(rd_data);
      end else begin
        live.exceptions <= live.exceptions + 1'b1;
      end
    end
  end

  // snapshot takes priority over clear so the final counts can still be read
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      snap_counts <= '0;
    end else if (ctrl.snap) begin
      snap_counts <= live;
    end else if (ctrl.clear) begin
      snap_counts <= '0;
    end
  end

  // after a clear the seed sample must arrive before any counted one
  ap_prime_before_take: assert property (@(posedge clk) disable iff (reset)
    ctrl.clear |=> (!ctrl.take until ctrl.prime))
    else $error("sample counted without a masked first sample");

endmodule

// ==== src/ber_monitor_top.sv ====
`timescale 1ns/1ps

module ber_monitor_top
  import ber_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [THRESH_W-1:0] threshold,
  input  logic [WINDOW_W-1:0] window_len,
  input  logic                count_en,
  input  logic                count_rst,
  input  logic                snap_shot,
  input  logic                tb_clk,
  input  logic [SAMPLE_W-1:0] tb_data,
  input  logic                tb_valid,
  output logic [WORD_W-1:0]   bit_high,
  output logic [WORD_W-1:0]   bit_low,
  output logic [WORD_W-1:0]   err_high,
  output logic [WORD_W-1:0]   err_low,
  output logic [WORD_W-1:0]   excp,
  output logic                meas_done,
  output ber_state_t          meas_state
);

  logic                                wr_reset_src;
  logic                                wr_reset;
  logic                                wr_en;
  logic [SYNC_DEPTH-1:0][SAMPLE_W-1:0] tb_data_pipe;
  logic                                rd_reset;
  logic                                rd_en;
  logic [SAMPLE_W-1:0]                 rd_data;
  logic                                empty;
  logic                                window_done;
  ber_counts_t                         snap_counts;

  ber_ctrl_if ctrl_if ();

  // either reset clears the write side, released in step with tb_clk
  assign wr_reset_src = reset | count_rst;

  ber_sync_bit #(.RESET_VAL(1'b1)) u_wr_reset_sync (
    .clk   (tb_clk),
    .reset (wr_reset_src),
    .d     (1'b0),
    .q     (wr_reset)
  );

  ber_sync_bit #(.RESET_VAL(1'b0)) u_valid_sync (
    .clk   (tb_clk),
    .reset (wr_reset),
    .d     (tb_valid),
    .q     (wr_en)
  );

  // the sample is delayed as far as its valid so each write stores its own sample
  always_ff @(posedge tb_clk) begin
    tb_data_pipe <= {tb_data_pipe[SYNC_DEPTH-2:0], tb_data};
  end

  // the read side clears with the write side so stale entries never survive
  assign rd_reset = reset | count_rst;

  ber_async_fifo u_fifo (
    .wr_clk   (tb_clk),
    .wr_reset (wr_reset),
    .wr_en    (wr_en),
    .wr_data  (tb_data_pipe[SYNC_DEPTH-1]),
    .clk      (clk),
    .reset    (rd_reset),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty)
  );

  ber_ctrl_fsm u_fsm (
    .clk         (clk),
    .reset       (reset),
    .count_en    (count_en),
    .count_rst   (count_rst),
    .snap_shot   (snap_shot),
    .empty       (empty),
    .window_done (window_done),
    .rd_en       (rd_en),
    .ctrl        (ctrl_if.controller),
    .state       (meas_state)
  );

  ber_window_timer u_timer (
    .clk         (clk),
    .reset       (reset),
    .window_len  (window_len),
    .ctrl        (ctrl_if.timer),
    .window_done (window_done)
  );

  ber_accumulator u_acc (
    .clk         (clk),
    .reset       (reset),
    .threshold   (threshold),
    .rd_data     (rd_data),
    .ctrl        (ctrl_if.accumulator),
    .snap_counts (snap_counts)
  );

  // the upper 12 bits of each 44-bit count are zero-extended into a full word
  assign bit_high = WORD_W'(snap_counts.bits[COUNT_W-1:WORD_W]);
  assign bit_low = snap_counts.bits[WORD_W-1:0];
  assign err_high = WORD_W'(snap_counts.errors[COUNT_W-1:WORD_W]);
  assign err_low = snap_counts.errors[WORD_W-1:0];
  assign excp = snap_counts.exceptions;

  assign meas_done = (meas_state == ST_DONE);

endmodule

// ==== include/ber_tb_checks.svh ====
`ifndef BER_TB_CHECKS_SVH
`define BER_TB_CHECKS_SVH

// compares all three read-out counts against the model in one go
task automatic check_counts(input string tag, input ber_counts_t got, input ber_counts_t exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s counts %0d/%0d/%0d exp %0d/%0d/%0d", $time, tag,
             got.bits, got.errors, got.exceptions, exp.bits, exp.errors, exp.exceptions);
    stop_with_failure();
  end
endtask

// the state is printed by name so a mismatch is readable in the log
task automatic check_state(input string tag, input ber_state_t got, input ber_state_t exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s state %s exp %s", $time, tag, got.name(), exp.name());
    stop_with_failure();
  end
endtask

task automatic check_done(input string tag, input logic got, input logic exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s meas_done %b exp %b", $time, tag, got, exp);
    stop_with_failure();
  end
endtask

// one 32-bit read-out word
task automatic check_word(input string tag, input logic [WORD_W-1:0] got,
                          input logic [WORD_W-1:0] exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s word %h exp %h", $time, tag, got, exp);
    stop_with_failure();
  end
endtask

// 32-bit xorshift, the caller keeps the state and takes the low bits as a sample
function automatic logic [31:0] xorshift32(input logic [31:0] seed);
  logic [31:0] x;
  x = seed;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

// ==== sim/ber_tb.sv ====
`timescale 1ns/1ps

module ber_tb
  import ber_pkg::*;
();

  localparam int WAIT_LIMIT = 1000;
  localparam int HOLD_CYCLES = 20;

  logic                clk = 1'b0;
  logic                tb_clk = 1'b0;
  logic                reset;
  logic [THRESH_W-1:0] threshold;
  logic [WINDOW_W-1:0] window_len;
  logic                count_en;
  logic                count_rst;
  logic                snap_shot;
  logic [SAMPLE_W-1:0] tb_data;
  logic                tb_valid;
  logic [WORD_W-1:0]   bit_high;
  logic [WORD_W-1:0]   bit_low;
  logic [WORD_W-1:0]   err_high;
  logic [WORD_W-1:0]   err_low;
  logic [WORD_W-1:0]   excp;
  logic                meas_done;
  ber_state_t          meas_state;

  // samples of the current window, the first one is the masked seed
  logic [SAMPLE_W-1:0] stim[$];
  logic [31:0]         rng = 32'hfa3e;
  ber_counts_t         saved;

  // the two clocks are unrelated so the FIFO sees a real crossing
  always #50 clk = ~clk;
  always #35 tb_clk = ~tb_clk;

  ber_monitor_top uut (
    .clk(clk), .reset(reset), .threshold(threshold), .window_len(window_len),
    .count_en(count_en), .count_rst(count_rst), .snap_shot(snap_shot),
    .tb_clk(tb_clk), .tb_data(tb_data), .tb_valid(tb_valid),
    .bit_high(bit_high), .bit_low(bit_low), .err_high(err_high), .err_low(err_low),
    .excp(excp), .meas_done(meas_done), .meas_state(meas_state)
  );

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "stopped at the first failing check");
  endtask

  `include "ber_tb_checks.svh"

  // rebuild the 44-bit counts from the register words
  function automatic ber_counts_t read_counts();
    ber_counts_t c;
    c.bits = {bit_high[COUNT_W-WORD_W-1:0], bit_low};
    c.errors = {err_high[COUNT_W-WORD_W-1:0], err_low};
    c.exceptions = excp;
    return c;
  endfunction

  // reference model: wrapped difference first, then the absolute value, else an exception
  function automatic ber_counts_t model_counts(input int thr);
    ber_counts_t m;
    int modulus;
    int step;
    m = '0;
    modulus = 1 << SAMPLE_W;
    for (int i = 1; i < stim.size(); i++) begin
      step = (int'(stim[i]) - int'(stim[i-1]) + modulus) % modulus;
      if (step <= thr) begin
        m.bits = m.bits + 1;
        m.errors = m.errors + step;
      end else if (int'(stim[i]) <= thr) begin
        m.bits = m.bits + 1;
        m.errors = m.errors + stim[i];
      end else begin
        m.exceptions = m.exceptions + 1;
      end
    end
    return m;
  endfunction

  task automatic wait_for_state(input ber_state_t want, input string tag);
    int cycles;
    cycles = 0;
    while (meas_state !== want) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout in %s while waiting for state %s", tag, want.name());
        stop_with_failure();
      end
    end
  endtask

  task automatic wait_for_done(input string tag);
    int cycles;
    cycles = 0;
    while (meas_done !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout in %s while waiting for meas_done", tag);
        stop_with_failure();
      end
    end
  endtask

  task automatic pulse_count_rst();
    @(posedge clk);
    count_rst <= 1'b1;
    @(posedge clk);
    count_rst <= 1'b0;
  endtask

  // outputs change on the edge where snap_shot is first seen, read them half a cycle later
  task automatic pulse_snapshot();
    @(posedge clk);
    snap_shot <= 1'b1;
    @(posedge clk);
    snap_shot <= 1'b0;
    @(negedge clk);
    // the high words carry 12 count bits and are zero above them
    check_word("bit_high top", bit_high >> (COUNT_W - WORD_W), '0);
    check_word("err_high top", err_high >> (COUNT_W - WORD_W), '0);
  endtask

  // one tb_clk of valid then one idle, slower than the clk side can read
  task automatic send_sample(input logic [SAMPLE_W-1:0] value);
    @(posedge tb_clk);
    tb_data <= value;
    tb_valid <= 1'b1;
    @(posedge tb_clk);
    tb_valid <= 1'b0;
  endtask

  task automatic fill_random(input int count);
    repeat (count) begin
      rng = xorshift32(rng);
      stim.push_back(rng[SAMPLE_W-1:0]);
    end
  endtask

  // one full window over stim, optionally with reads held off until all samples sit in the FIFO
  task automatic run_window(input string tag, input int thr, input logic hold);
    @(posedge clk);
    threshold <= THRESH_W'(thr);
    window_len <= WINDOW_W'(stim.size() - 1);
    count_en <= !hold;
    pulse_count_rst();
    wait_for_state(ST_PRIME, tag);
    foreach (stim[i]) begin
      send_sample(stim[i]);
    end
    if (hold) begin
      repeat (HOLD_CYCLES) @(negedge clk);
      check_done(tag, meas_done, 1'b0);
      check_state(tag, meas_state, ST_PRIME);
      pulse_snapshot();
      check_counts(tag, read_counts(), '0);
      @(posedge clk);
      count_en <= 1'b1;
    end
    wait_for_done(tag);
    pulse_snapshot();
    check_counts(tag, read_counts(), model_counts(thr));
    check_done(tag, meas_done, 1'b1);
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_counts("reset", read_counts(), '0);
    check_state("reset", meas_state, ST_IDLE);
    check_done("reset", meas_done, 1'b0);
    pulse_count_rst();
    @(negedge clk);
    check_state("leave idle", meas_state, ST_FLUSH);
  endtask

  // steps 0 to 3 from a start of 5 give 8 valid steps summing to 12
  task automatic test_small_steps();
    stim = {7'd5, 7'd5, 7'd6, 7'd8, 7'd11, 7'd11, 7'd12, 7'd14, 7'd17};
    run_window("small steps", 8, 1'b0);
    check_counts("small sum", read_counts(),
                 ber_counts_t'{bits: 44'd8, errors: 44'd12, exceptions: 32'd0});
  endtask

  // a wrap, two restarts and two exceptions mixed with plain steps
  task automatic test_wrap_restart();
    stim = {7'd120, 7'd125, 7'd3, 7'd60, 7'd4, 7'd90, 7'd95, 7'd2};
    run_window("wrap restart", 10, 1'b0);
    check_counts("wrap literal", read_counts(),
                 ber_counts_t'{bits: 44'd5, errors: 44'd22, exceptions: 32'd2});
  endtask

  task automatic test_random();
    stim = {};
    fill_random(16);
    run_window("random low", 20, 1'b0);
    stim = {};
    fill_random(16);
    run_window("random high", 100, 1'b0);
  endtask

  // the window spans two batches so the live counts move on after the first snapshot
  task automatic test_snapshot_isolation();
    stim = {};
    fill_random(6);
    @(posedge clk);
    threshold <= THRESH_W'(30);
    window_len <= WINDOW_W'(9);
    count_en <= 1'b1;
    pulse_count_rst();
    wait_for_state(ST_PRIME, "isolate first");
    foreach (stim[i]) begin
      send_sample(stim[i]);
    end
    repeat (HOLD_CYCLES) @(negedge clk);
    pulse_snapshot();
    saved = model_counts(30);
    check_counts("isolate first", read_counts(), saved);
    // these reach the live counters but no snapshot follows them yet
    fill_random(4);
    for (int i = 6; i < stim.size(); i++) begin
      send_sample(stim[i]);
    end
    wait_for_done("isolate hold");
    check_counts("isolate hold", read_counts(), saved);
    pulse_snapshot();
    check_counts("isolate full", read_counts(), model_counts(30));
    pulse_count_rst();
    @(negedge clk);
    check_counts("isolate clear", read_counts(), '0);
    stim = {};
    fill_random(7);
    run_window("isolate second", 50, 1'b0);
  endtask

  // six samples stay under the eight-entry depth
  task automatic test_count_enable_hold();
    stim = {7'd10, 7'd12, 7'd15, 7'd100, 7'd3, 7'd7};
    run_window("count_en hold", 12, 1'b1);
  endtask

  initial begin
    reset <= 1'b1;
    threshold <= '0;
    window_len <= '0;
    count_en <= 1'b0;
    count_rst <= 1'b0;
    snap_shot <= 1'b0;
    tb_data <= '0;
    tb_valid <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_small_steps();
    test_wrap_restart();
    test_random();
    test_snapshot_isolation();
    test_count_enable_hold();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
src/ber_pkg.sv
src/ber_sync_bit.sv
src/ber_async_fifo.sv
src/ber_ctrl_if.sv
src/ber_ctrl_fsm.sv
src/ber_window_timer.sv
src/ber_accumulator.sv
src/ber_monitor_top.sv
sim/ber_tb.sv
